//--- flist.f
+incdir+hdl
hdl/wbuf_pkg.sv
hdl/mem_pkg.sv
hdl/wbuf_req_decode.sv
hdl/wbuf_store.sv
hdl/wbuf_tx_issue.sv
hdl/wbuf_rtrn.sv
hdl/wbuf_top.sv
tb/tb_wbuf.sv

//--- run.sh
#!/bin/sh
# build the write buffer testbench with Verilator and run it
# exit status is non-zero when the build, the run or a check fails

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -f flist.f --top-module tb_wbuf -Mdir obj_dir -o sim_wbuf
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_wbuf > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  exit 1
fi
exit 0

//--- tb/tb_wbuf.sv
// directed testbench for the coalescing write buffer
// memory side is modelled by tasks that ack requests and return IDs
`timescale 1ns/1ps

module tb_wbuf import wbuf_pkg::*, mem_pkg::*; ();

  localparam int unsigned SEED = 32'h2f40b42e;
  // six tests of well under 200 cycles each plus the reset phase
  localparam int MAX_CYCLES = 5000;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  wbuf_req_t store_i;
  logic      gnt_o;
  logic      miss_req_o;
  mem_tx_t   miss_o;
  logic      miss_ack_i;
  logic      miss_rtrn_vld_i;
  mem_id_t   miss_rtrn_id_i;
  logic      empty_o;
  int        cycles = 0;
  int        errors = 0;
  int        checks = 0;
  int        tests = 0;

  wbuf_top DUT (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .store_i         ( store_i         ),
    .gnt_o           ( gnt_o           ),
    .miss_req_o      ( miss_req_o      ),
    .miss_o          ( miss_o          ),
    .miss_ack_i      ( miss_ack_i      ),
    .miss_rtrn_vld_i ( miss_rtrn_vld_i ),
    .miss_rtrn_id_i  ( miss_rtrn_id_i  ),
    .empty_o         ( empty_o         )
  );

  always #5 clk_i = ~clk_i;

  // hung run guard
  always @(posedge clk_i) begin : p_watchdog
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  function automatic logic [63:0] rand_word();
    return {$urandom, $urandom};
  endfunction

  // bytes under be come from new_w
  function automatic logic [63:0] merge_bytes(input logic [63:0] old_w,
                                              input logic [63:0] new_w,
                                              input wbuf_be_t be);
    logic [63:0] r;
    r = old_w;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        r[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return r;
  endfunction

  // first aligned piece of the dirty bytes with its data repeated over 64 bits
  function automatic mem_tx_t expect_piece(input logic [31:0] waddr, input wbuf_be_t dirty,
                                           input logic [63:0] data, input mem_id_t id);
    mem_tx_t t;
    int      o;
    int      n;
    o = 0;
    while (o < 7 && !dirty[o]) begin
      o++;
    end
    if (o == 0 && dirty == 8'hff) begin
      n = 8;
    end else if (o % 4 == 0 && dirty[o] && dirty[o+1] && dirty[o+2] && dirty[o+3]) begin
      n = 4;
    end else if (o % 2 == 0 && dirty[o+1]) begin
      n = 2;
    end else begin
      n = 1;
    end
    case (n)
      8:       t.size = MEM_DWORD;
      4:       t.size = MEM_WORD;
      2:       t.size = MEM_HALF;
      default: t.size = MEM_BYTE;
    endcase
    t.paddr = waddr + 32'(o);
    t.id    = id;
    for (int i = 0; i < 64; i++) begin
      t.wdata[i] = data[o*8 + (i % (n*8))];
    end
    return t;
  endfunction

  // bytes carried by a request
  function automatic wbuf_be_t piece_mask(input mem_tx_t t);
    int n;
    n = 1 << int'(t.size);
    return wbuf_be_t'((1 << n) - 1) << t.paddr[2:0];
  endfunction

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // id compared only where the test knows which slot is free
  task automatic check_tx(input string what, input mem_tx_t got, input mem_tx_t exp,
                          input logic with_id);
    checks++;
    if (got.paddr !== exp.paddr || got.wdata !== exp.wdata || got.size !== exp.size ||
        (with_id && got.id !== exp.id)) begin
      errors++;
      $display("ERR %0t: %s: got addr %h data %h size %0d id %0d, %s %h data %h size %0d id %0d",
               $time, what, got.paddr, got.wdata, got.size, got.id,
               "expected addr", exp.paddr, exp.wdata, exp.size, exp.id);
    end
  endtask

  //////////////////////////////////////////////////
  // bus drivers and memory model
  //////////////////////////////////////////////////

  // hold the store until granted and release it on the granting edge
  task automatic do_store(input logic [31:0] a, input logic [63:0] d, input wbuf_be_t be);
    @(posedge clk_i);
    store_i.req   <= 1'b1;
    store_i.paddr <= a;
    store_i.wdata <= d;
    store_i.be    <= be;
    @(negedge clk_i);
    while (!gnt_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    store_i.req <= 1'b0;
  endtask

  // offer a store for one cycle only
  task automatic try_store(input logic [31:0] a, input logic [63:0] d, input wbuf_be_t be,
                           output logic granted);
    @(posedge clk_i);
    store_i.req   <= 1'b1;
    store_i.paddr <= a;
    store_i.wdata <= d;
    store_i.be    <= be;
    @(negedge clk_i);
    granted = gnt_o;
    @(posedge clk_i);
    store_i.req <= 1'b0;
  endtask

  // wait for a request, stall one cycle, then ack it
  task automatic take_req(output mem_tx_t tx);
    @(negedge clk_i);
    while (!miss_req_o) begin
      @(negedge clk_i);
    end
    tx = miss_o;
    @(posedge clk_i);
    miss_ack_i <= 1'b1;
    @(negedge clk_i);
    check_bit("request dropped before ack", miss_req_o, 1'b1);
    check_tx("request changed while stalled", miss_o, tx, 1'b1);
    @(posedge clk_i);
    miss_ack_i <= 1'b0;
  endtask

  task automatic send_rtrn(input mem_id_t id);
    @(posedge clk_i);
    miss_rtrn_vld_i <= 1'b1;
    miss_rtrn_id_i  <= id;
    @(posedge clk_i);
    miss_rtrn_vld_i <= 1'b0;
  endtask

  task automatic expect_idle(input int n, input string what);
    repeat (n) begin
      @(negedge clk_i);
      check_bit(what, miss_req_o, 1'b0);
    end
  endtask

  task automatic wait_empty();
    @(negedge clk_i);
    while (!empty_o) begin
      @(negedge clk_i);
    end
    check_bit("request left after drain", miss_req_o, 1'b0);
  endtask

  task automatic report(input string name, input int err0);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - err0);
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic dword_store();
    int          e0;
    logic [63:0] d;
    logic        g;
    mem_tx_t     tx;
    e0 = errors;
    d  = rand_word();
    // the buffer is empty after reset so the first store is granted at once
    try_store(32'h0000_1000, d, 8'hff, g);
    check_bit("grant on empty buffer", g, 1'b1);
    @(negedge clk_i);
    check_bit("empty with one word held", empty_o, 1'b0);
    take_req(tx);
    check_tx("dword request", tx, expect_piece(32'h0000_1000, 8'hff, d, 2'd0), 1'b1);
    expect_idle(2, "request after the only piece");
    send_rtrn(tx.id);
    wait_empty();
    report("dword store", e0);
  endtask

  task automatic coalesce_two();
    int          e0;
    logic [63:0] d1, d2;
    mem_tx_t     tx;
    e0 = errors;
    d1 = rand_word();
    d2 = rand_word();
    // masks 3c and c3 together cover the word
    do_store(32'h0000_2008, d1, 8'h3c);
    do_store(32'h0000_2008, d2, 8'hc3);
    take_req(tx);
    check_tx("merged request", tx,
             expect_piece(32'h0000_2008, 8'hff, merge_bytes(d1, d2, 8'hc3), 2'd0), 1'b1);
    expect_idle(2, "second request after merge");
    send_rtrn(tx.id);
    wait_empty();
    report("coalesce two stores", e0);
  endtask

  task automatic split_pieces();
    int          e0;
    logic [63:0] d;
    wbuf_be_t    dirty;
    logic [14:0] seq;
    mem_tx_t     tx;
    e0    = errors;
    d     = rand_word();
    dirty = 8'h39;
    seq   = '0;
    do_store(32'h0000_3010, d, dirty);
    for (int k = 0; k < 3; k++) begin
      take_req(tx);
      check_tx($sformatf("piece %0d", k), tx, expect_piece(32'h0000_3010, dirty, d, 2'd0), 1'b1);
      seq   = {seq[9:0], tx.paddr[2:0], 2'(tx.size)};
      dirty = dirty & ~piece_mask(tx);
      send_rtrn(tx.id);
    end
    // offset and size code per piece for a byte at 0, a byte at 3 and a half at 4
    check_val("piece order", 64'(seq), 64'({3'd0, 2'd0, 3'd3, 2'd0, 3'd4, 2'd1}));
    wait_empty();
    report("split into aligned pieces", e0);
  endtask

  task automatic rewrite_in_flight();
    int          e0;
    logic [63:0] d1, d2;
    mem_tx_t     tx;
    e0 = errors;
    d1 = rand_word();
    d2 = rand_word();
    do_store(32'h0000_5020, d1, 8'hff);
    take_req(tx);
    check_tx("first dword", tx, expect_piece(32'h0000_5020, 8'hff, d1, 2'd0), 1'b1);
    do_store(32'h0000_5020, d2, 8'h04);
    expect_idle(4, "request while word in flight");
    send_rtrn(tx.id);
    take_req(tx);
    check_tx("rewritten byte", tx,
             expect_piece(32'h0000_5020, 8'h04, merge_bytes(d1, d2, 8'h04), 2'd0), 1'b1);
    send_rtrn(tx.id);
    wait_empty();
    report("rewrite while in flight", e0);
  endtask

  task automatic full_buffer();
    int          e0;
    logic [31:0] wa [8];
    logic [63:0] wd [8];
    logic [63:0] extra;
    logic        g;
    mem_tx_t     tx;
    e0 = errors;
    for (int k = 0; k < 8; k++) begin
      wa[k] = 32'h0001_0000 + 32'(k) * 32'h40;
      wd[k] = rand_word();
      do_store(wa[k], wd[k], 8'hff);
    end
    try_store(32'h0002_0000, rand_word(), 8'hff, g);
    check_bit("grant to new word when full", g, 1'b0);
    extra = rand_word();
    try_store(wa[3], extra, 8'h01, g);
    check_bit("grant to held word when full", g, 1'b1);
    wd[3] = merge_bytes(wd[3], extra, 8'h01);
    // entries were claimed in order and the lowest dirty entry goes first
    for (int k = 0; k < 8; k++) begin
      take_req(tx);
      check_tx($sformatf("drain word %0d", k), tx, expect_piece(wa[k], 8'hff, wd[k], 2'd0), 1'b0);
      send_rtrn(tx.id);
    end
    wait_empty();
    report("full buffer", e0);
  endtask

  task automatic slot_limit();
    int          e0;
    logic [31:0] wa [5];
    logic [63:0] wd [5];
    mem_tx_t     tx;
    e0 = errors;
    for (int k = 0; k < 5; k++) begin
      wa[k] = 32'h0003_0000 + 32'(k) * 32'h8;
      wd[k] = rand_word();
      do_store(wa[k], wd[k], 8'hff);
    end
    for (int k = 0; k < 4; k++) begin
      take_req(tx);
      check_tx($sformatf("slot %0d", k), tx,
               expect_piece(wa[k], 8'hff, wd[k], mem_id_t'(k)), 1'b1);
    end
    expect_idle(4, "request with all slots busy");
    for (int k = 3; k >= 0; k--) begin
      send_rtrn(mem_id_t'(k));
    end
    take_req(tx);
    check_tx("word after slots freed", tx, expect_piece(wa[4], 8'hff, wd[4], 2'd0), 1'b0);
    send_rtrn(tx.id);
    wait_empty();
    report("slot limit and reverse returns", e0);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin : p_main
    void'($urandom(SEED));
    rst_ni          <= 1'b0;
    store_i         <= '0;
    miss_ack_i      <= 1'b0;
    miss_rtrn_vld_i <= 1'b0;
    miss_rtrn_id_i  <= '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_bit("empty after reset", empty_o, 1'b1);
    check_bit("request after reset", miss_req_o, 1'b0);

    dword_store();
    coalesce_two();
    split_pieces();
    rewrite_in_flight();
    full_buffer();
    slot_limit();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/wbuf_top.sv
// coalescing write buffer between a core store port and memory
// store decode, entry array, transaction issue and response retirement
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_top import wbuf_pkg::*, mem_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // core store port
  input  wbuf_req_t store_i,
  output logic      gnt_o,
  // write requests to memory
  output logic      miss_req_o,
  output mem_tx_t   miss_o,
  input  logic      miss_ack_i,
  // write responses
  input  logic      miss_rtrn_vld_i,
  input  mem_id_t   miss_rtrn_id_i,
  output logic      empty_o
);

  wbuf_entry_t [`WBUF_DEPTH-1:0]  entries;
  mem_slot_t   [`WBUF_MAX_TX-1:0] slots;
  logic      wr_en, wr_new, iss_en, ret_en, free_en;
  wbuf_ptr_t wr_ptr, iss_ptr, ret_ptr;
  wbuf_be_t  iss_be, ret_be;
  mem_id_t   free_id;

  wbuf_req_decode i_decode (
    .store_i   ( store_i ),
    .entries_i ( entries ),
    .gnt_o     ( gnt_o   ),
    .wr_en_o   ( wr_en   ),
    .wr_ptr_o  ( wr_ptr  ),
    .wr_new_o  ( wr_new  )
  );

  wbuf_store i_store (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .store_i   ( store_i ),
    .wr_en_i   ( wr_en   ),
    .wr_ptr_i  ( wr_ptr  ),
    .wr_new_i  ( wr_new  ),
    .iss_en_i  ( iss_en  ),
    .iss_ptr_i ( iss_ptr ),
    .iss_be_i  ( iss_be  ),
    .ret_en_i  ( ret_en  ),
    .ret_ptr_i ( ret_ptr ),
    .ret_be_i  ( ret_be  ),
    .entries_o ( entries ),
    .empty_o   ( empty_o )
  );

  wbuf_tx_issue i_issue (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .entries_i  ( entries    ),
    .miss_ack_i ( miss_ack_i ),
    .free_en_i  ( free_en    ),
    .free_id_i  ( free_id    ),
    .miss_req_o ( miss_req_o ),
    .miss_o     ( miss_o     ),
    .iss_en_o   ( iss_en     ),
    .iss_ptr_o  ( iss_ptr    ),
    .iss_be_o   ( iss_be     ),
    .slots_o    ( slots      )
  );

  wbuf_rtrn i_rtrn (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .miss_rtrn_vld_i ( miss_rtrn_vld_i ),
    .miss_rtrn_id_i  ( miss_rtrn_id_i  ),
    .slots_i         ( slots           ),
    .ret_en_o        ( ret_en          ),
    .ret_ptr_o       ( ret_ptr         ),
    .ret_be_o        ( ret_be          ),
    .free_en_o       ( free_en         ),
    .free_id_o       ( free_id         )
  );

endmodule

//--- hdl/wbuf_rtrn.sv
// response retirement: queue returned IDs and retire one per cycle
// against the entry and bytes recorded in its slot
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_rtrn import wbuf_pkg::*, mem_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         miss_rtrn_vld_i,
  input  mem_id_t                      miss_rtrn_id_i,
  input  mem_slot_t [`WBUF_MAX_TX-1:0] slots_i,
  output logic                         ret_en_o,
  output wbuf_ptr_t                    ret_ptr_o,
  output wbuf_be_t                     ret_be_o,
  output logic                         free_en_o,
  output mem_id_t                      free_id_o
);

  localparam int unsigned AW = $clog2(`WBUF_MAX_TX);

  mem_id_t [`WBUF_MAX_TX-1:0] fifo_q;
  logic    [AW-1:0]           wr_ptr_q;
  logic    [AW-1:0]           rd_ptr_q;
  logic    [AW:0]             cnt_q;
  logic                       pop;
  mem_id_t                    head;

  // one slot per outstanding ID, so the queue cannot overflow
  // not fall-through, an ID is seen one cycle after its strobe
  assign pop  = (cnt_q != '0);
  assign head = fifo_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ptrs
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (miss_rtrn_vld_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (miss_rtrn_vld_i && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!miss_rtrn_vld_i && pop) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_fifo
    if (miss_rtrn_vld_i) begin
      fifo_q[wr_ptr_q] <= miss_rtrn_id_i;
    end
  end

  // retire the head now, entry and slot update on the next edge
  assign ret_en_o  = pop;
  assign ret_ptr_o = slots_i[head].ptr;
  assign ret_be_o  = slots_i[head].be;
  assign free_en_o = pop;
  assign free_id_o = head;

endmodule

//--- hdl/wbuf_tx_issue.sv
// transaction issue: choose the next dirty piece, size and align it,
// drive the memory request and keep the table of in-flight slots
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_tx_issue import wbuf_pkg::*, mem_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  wbuf_entry_t [`WBUF_DEPTH-1:0] entries_i,
  input  logic                          miss_ack_i,
  input  logic                          free_en_i,
  input  mem_id_t                       free_id_i,
  output logic                          miss_req_o,
  output mem_tx_t                       miss_o,
  output logic                          iss_en_o,
  output wbuf_ptr_t                     iss_ptr_o,
  output wbuf_be_t                      iss_be_o,
  output mem_slot_t [`WBUF_MAX_TX-1:0]  slots_o
);

  logic      [`WBUF_DEPTH-1:0]  elig;
  logic      [`WBUF_MAX_TX-1:0] slot_vld_q;
  wbuf_ptr_t [`WBUF_MAX_TX-1:0] slot_ptr_q;
  wbuf_be_t  [`WBUF_MAX_TX-1:0] slot_be_q;
  wbuf_ptr_t                    low_ptr, sel_ptr, lock_ptr_q;
  mem_id_t                      low_id, sel_id, lock_id_q;
  logic                         lock_q;
  logic                         accept;
  wbuf_entry_t                  sel;
  wbuf_be_t                     bshift, size_mask;
  logic      [`WBUF_OFFW-1:0]   off;
  logic      [`WBUF_XLEN-1:0]   sdata;
  mem_size_e                    size;

  // an entry already in flight waits, pieces must not overtake
  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_elig
    assign elig[k] = (|entries_i[k].dirty) && !(|entries_i[k].txblock);
  end

  always_comb begin : p_lowest
    low_ptr = '0;
    low_id  = '0;
    for (int k = `WBUF_DEPTH-1; k >= 0; k--) begin
      if (elig[k]) begin
        low_ptr = wbuf_ptr_t'(k);
      end
    end
    for (int k = `WBUF_MAX_TX-1; k >= 0; k--) begin
      if (!slot_vld_q[k]) begin
        low_id = mem_id_t'(k);
      end
    end
  end

  // hold the choice while memory stalls
  assign sel_ptr = lock_q ? lock_ptr_q : low_ptr;
  assign sel_id  = lock_q ? lock_id_q  : low_id;
  assign sel     = entries_i[sel_ptr];

  //////////////////////////////////////////////////
  // piece size, mask and data
  //////////////////////////////////////////////////

  always_comb begin : p_off
    off = '0;
    for (int k = `WBUF_NBYTES-1; k >= 0; k--) begin
      if (sel.dirty[k]) begin
        off = k[`WBUF_OFFW-1:0];
      end
    end
  end

  assign bshift = sel.dirty >> off;
  assign sdata  = sel.data >> {off, 3'b000};

  // largest naturally aligned run starting at the offset
  always_comb begin : p_size
    if (off == '0 && (&sel.dirty)) begin
      size      = MEM_DWORD;
      size_mask = '1;
    end else if (off[1:0] == 2'b00 && (&bshift[3:0])) begin
      size      = MEM_WORD;
      size_mask = wbuf_be_t'(4'hf);
    end else if (!off[0] && bshift[1]) begin
      size      = MEM_HALF;
      size_mask = wbuf_be_t'(2'h3);
    end else begin
      size      = MEM_BYTE;
      size_mask = wbuf_be_t'(1'b1);
    end
  end

  always_comb begin : p_tx
    miss_o.paddr = {sel.wtag, off};
    miss_o.size  = size;
    miss_o.id    = sel_id;
    // replicate short pieces over the full word
    case (size)
      MEM_DWORD: miss_o.wdata = sel.data;
      MEM_WORD:  miss_o.wdata = {(`WBUF_XLEN/32){sdata[31:0]}};
      MEM_HALF:  miss_o.wdata = {(`WBUF_XLEN/16){sdata[15:0]}};
      default:   miss_o.wdata = {(`WBUF_XLEN/8){sdata[7:0]}};
    endcase
  end

  assign miss_req_o = (|elig) && !(&slot_vld_q);
  assign accept     = miss_req_o && miss_ack_i;
  assign iss_en_o   = accept;
  assign iss_ptr_o  = sel_ptr;
  assign iss_be_o   = size_mask << off;

  //////////////////////////////////////////////////
  // slot table and lock
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      slot_vld_q <= '0;
      lock_q     <= 1'b0;
    end else begin
      // freed and allocated slots never coincide
      if (free_en_i) begin
        slot_vld_q[free_id_i] <= 1'b0;
      end
      if (accept) begin
        slot_vld_q[sel_id] <= 1'b1;
      end
      lock_q <= miss_req_o && !miss_ack_i;
    end
  end

  always_ff @(posedge clk_i) begin : p_slot_data
    lock_ptr_q <= sel_ptr;
    lock_id_q  <= sel_id;
    if (accept) begin
      slot_ptr_q[sel_id] <= sel_ptr;
      slot_be_q[sel_id]  <= iss_be_o;
    end
  end

  for (genvar k = 0; k < `WBUF_MAX_TX; k++) begin : gen_slots
    assign slots_o[k].vld = slot_vld_q[k];
    assign slots_o[k].ptr = slot_ptr_q[k];
    assign slots_o[k].be  = slot_be_q[k];
  end

endmodule

//--- hdl/wbuf_store.sv
// buffer entry array with per-byte valid/dirty/txblock tracking
// applies store writes, issue marks and retirement each cycle
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_store import wbuf_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  wbuf_req_t                     store_i,
  input  logic                          wr_en_i,
  input  wbuf_ptr_t                     wr_ptr_i,
  input  logic                          wr_new_i,
  input  logic                          iss_en_i,
  input  wbuf_ptr_t                     iss_ptr_i,
  input  wbuf_be_t                      iss_be_i,
  input  logic                          ret_en_i,
  input  wbuf_ptr_t                     ret_ptr_i,
  input  wbuf_be_t                      ret_be_i,
  output wbuf_entry_t [`WBUF_DEPTH-1:0] entries_o,
  output logic                          empty_o
);

  wbuf_be_t   [`WBUF_DEPTH-1:0]                 valid_d, valid_q;
  wbuf_be_t   [`WBUF_DEPTH-1:0]                 dirty_d, dirty_q;
  wbuf_be_t   [`WBUF_DEPTH-1:0]                 txblk_d, txblk_q;
  wbuf_wtag_t [`WBUF_DEPTH-1:0]                 wtag_q;
  logic       [`WBUF_DEPTH-1:0][`WBUF_XLEN-1:0] data_q;
  logic       [`WBUF_DEPTH-1:0]                 used;

  //////////////////////////////////////////////////
  // byte state update
  //////////////////////////////////////////////////

  always_comb begin : p_state
    valid_d = valid_q;
    dirty_d = dirty_q;
    txblk_d = txblk_q;

    // response back: unblock, free bytes not rewritten meanwhile
    if (ret_en_i) begin
      txblk_d[ret_ptr_i] = txblk_q[ret_ptr_i] & ~ret_be_i;
      valid_d[ret_ptr_i] = valid_q[ret_ptr_i] & ~(ret_be_i & ~dirty_q[ret_ptr_i]);
    end

    // accepted piece moves from dirty to in flight
    if (iss_en_i) begin
      dirty_d[iss_ptr_i] = dirty_d[iss_ptr_i] & ~iss_be_i;
      txblk_d[iss_ptr_i] = txblk_d[iss_ptr_i] | iss_be_i;
    end

    // store applied last, a rewrite of an in-flight byte gives 1/1/1
    if (wr_en_i) begin
      valid_d[wr_ptr_i] = valid_d[wr_ptr_i] | store_i.be;
      dirty_d[wr_ptr_i] = dirty_d[wr_ptr_i] | store_i.be;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state_regs
    if (!rst_ni) begin
      valid_q <= '0;
      dirty_q <= '0;
      txblk_q <= '0;
    end else begin
      valid_q <= valid_d;
      dirty_q <= dirty_d;
      txblk_q <= txblk_d;
    end
  end

  //////////////////////////////////////////////////
  // tag and data
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin : p_payload
    if (wr_en_i) begin
      // tag only changes when a free entry is claimed
      if (wr_new_i) begin
        wtag_q[wr_ptr_i] <= store_i.paddr[`WBUF_PLEN-1:`WBUF_OFFW];
      end
      for (int b = 0; b < `WBUF_NBYTES; b++) begin
        if (store_i.be[b]) begin
          data_q[wr_ptr_i][b*8 +: 8] <= store_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_out
    assign entries_o[k].wtag    = wtag_q[k];
    assign entries_o[k].data    = data_q[k];
    assign entries_o[k].valid   = valid_q[k];
    assign entries_o[k].dirty   = dirty_q[k];
    assign entries_o[k].txblock = txblk_q[k];
    assign used[k]              = |valid_q[k];
  end

  assign empty_o = ~|used;

endmodule

//--- hdl/wbuf_req_decode.sv
// store-request decode: match the store's word against the buffer
// and pick the entry to write, or hold off the grant when full
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_req_decode import wbuf_pkg::*; (
  input  wbuf_req_t                     store_i,
  input  wbuf_entry_t [`WBUF_DEPTH-1:0] entries_i,
  output logic                          gnt_o,
  output logic                          wr_en_o,
  output wbuf_ptr_t                     wr_ptr_o,
  output logic                          wr_new_o
);

  wbuf_wtag_t             req_wtag;
  logic [`WBUF_DEPTH-1:0] used;
  logic [`WBUF_DEPTH-1:0] hit;
  wbuf_ptr_t              hit_ptr;
  wbuf_ptr_t              free_ptr;
  logic                   any_hit;
  logic                   full;

  assign req_wtag = store_i.paddr[`WBUF_PLEN-1:`WBUF_OFFW];

  // an entry is in use as long as one byte is valid
  for (genvar k = 0; k < `WBUF_DEPTH; k++) begin : gen_match
    assign used[k] = |entries_i[k].valid;
    assign hit[k]  = used[k] && (entries_i[k].wtag == req_wtag);
  end

  // lowest index wins, scan downward so the last hit sticks
  always_comb begin : p_pick
    hit_ptr  = '0;
    free_ptr = '0;
    for (int k = `WBUF_DEPTH-1; k >= 0; k--) begin
      if (hit[k]) begin
        hit_ptr = wbuf_ptr_t'(k);
      end
      if (!used[k]) begin
        free_ptr = wbuf_ptr_t'(k);
      end
    end
  end

  assign any_hit = |hit;
  assign full    = &used;

  // coalesce into a hit, else claim a free entry
  assign gnt_o    = store_i.req && (any_hit || !full);
  assign wr_en_o  = gnt_o;
  assign wr_new_o = !any_hit;
  assign wr_ptr_o = any_hit ? hit_ptr : free_ptr;

endmodule

//--- hdl/mem_pkg.sv
// memory-side types: outgoing write requests, sizes, IDs and slots
// imported by the issue and return logic and the top level
`include "wbuf_defs.svh"

package mem_pkg;

  // transaction ID, one per slot
  typedef logic [$clog2(`WBUF_MAX_TX)-1:0] mem_id_t;

  // naturally aligned piece sizes
  typedef enum logic [1:0] {
    MEM_BYTE  = 2'b00,
    MEM_HALF  = 2'b01,
    MEM_WORD  = 2'b10,
    MEM_DWORD = 2'b11
  } mem_size_e;

  // write request toward memory, data replicated across the word
  typedef struct packed {
    logic [`WBUF_PLEN-1:0] paddr;
    logic [`WBUF_XLEN-1:0] wdata;
    mem_size_e             size;
    mem_id_t               id;
  } mem_tx_t;

  // in-flight record: owning entry and the bytes it carries
  typedef struct packed {
    logic                            vld;
    logic [$clog2(`WBUF_DEPTH)-1:0]  ptr;
    logic [`WBUF_NBYTES-1:0]         be;
  } mem_slot_t;

endpackage

//--- hdl/wbuf_pkg.sv
// buffer-side types: core store requests and buffer entries
// imported by the decode, entry store, issue and return logic
`include "wbuf_defs.svh"

package wbuf_pkg;

  // byte enables over one data word
  typedef logic [`WBUF_NBYTES-1:0] wbuf_be_t;

  // index of a buffer entry
  typedef logic [$clog2(`WBUF_DEPTH)-1:0] wbuf_ptr_t;

  // aligned word address, byte offset stripped
  typedef logic [`WBUF_PLEN-`WBUF_OFFW-1:0] wbuf_wtag_t;

  // store request from the core
  typedef struct packed {
    logic                  req;
    logic [`WBUF_PLEN-1:0] paddr;
    logic [`WBUF_XLEN-1:0] wdata;
    wbuf_be_t              be;
  } wbuf_req_t;

  // one buffer word
  // per byte valid/dirty/txblock is one of 000, 110, 101, 111
  // 111 means rewritten while in flight, so it goes out again
  typedef struct packed {
    wbuf_wtag_t            wtag;
    logic [`WBUF_XLEN-1:0] data;
    wbuf_be_t              valid;
    wbuf_be_t              dirty;
    wbuf_be_t              txblock;
  } wbuf_entry_t;

endpackage

//--- hdl/wbuf_defs.svh
// sizing macros for the coalescing write buffer
// include wherever buffer or transaction widths are needed
`ifndef WBUF_DEFS_SVH
`define WBUF_DEFS_SVH

// entries in the buffer, one aligned data word each
`define WBUF_DEPTH 8
// memory transactions that may be in flight at once
`define WBUF_MAX_TX 4
// data word width in bits
`define WBUF_XLEN 64
// physical address width in bits
`define WBUF_PLEN 32
// bytes per data word and byte offset bits within a word
`define WBUF_NBYTES (`WBUF_XLEN/8)
`define WBUF_OFFW ($clog2(`WBUF_XLEN/8))

`endif
